/* Bender.yml */
package:
  name: gcm_auth

sources:
  - files:
      - hw/gcm_pkg.sv
      - hw/gf128_pkg.sv
      - hw/gcm_stage_if.sv
      - hw/gcm_ctrl.sv
      - hw/ghash_stage.sv
      - hw/gcm_len_counter.sv
      - hw/gcm_tag_unit.sv
      - hw/gcm_auth_top.sv
  - target: test
    files:
      - testbench/tb_gcm_auth.sv

/* build.f */
hw/gcm_pkg.sv
hw/gf128_pkg.sv
hw/gcm_stage_if.sv
hw/gcm_ctrl.sv
hw/ghash_stage.sv
hw/gcm_len_counter.sv
hw/gcm_tag_unit.sv
hw/gcm_auth_top.sv
testbench/tb_gcm_auth.sv

/* hw/gcm_auth_top.sv */
module gcm_auth_top
    import gcm_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,

    // message start with its keys
    input  logic     i_start,
    input  gcm_blk_t i_h,
    input  gcm_blk_t i_ekj0,

    // aad and ciphertext blocks
    input  logic     i_blk_valid,
    input  gcm_blk_t i_blk_data,
    input  logic     i_blk_is_aad,
    input  logic     i_finish,

    output gcm_blk_t o_tag,
    output logic     o_tag_valid,
    output logic     o_busy,
    output logic     o_seq_error
);

    gcm_len_t w_len_blk;
    gcm_blk_t w_s;
    logic     w_s_update;

    gcm_stage_if stage_if ();

    gcm_ctrl u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_blk_valid  (i_blk_valid),
        .i_blk_data   (i_blk_data),
        .i_blk_is_aad (i_blk_is_aad),
        .i_finish     (i_finish),
        .i_len_blk    (w_len_blk),
        .o_busy       (o_busy),
        .o_seq_error  (o_seq_error),
        .stage        (stage_if.ctrl)
    );

    gcm_len_counter u_len_counter (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .stage     (stage_if.dp),
        .o_len_blk (w_len_blk)
    );

    ghash_stage u_ghash_stage (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_h        (i_h),
        .stage      (stage_if.dp),
        .o_s        (w_s),
        .o_s_update (w_s_update)
    );

    gcm_tag_unit u_tag_unit (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_ekj0      (i_ekj0),
        .i_s         (w_s),
        .i_s_update  (w_s_update),
        .o_tag       (o_tag),
        .o_tag_valid (o_tag_valid)
    );

endmodule

/* hw/gcm_ctrl.sv */
module gcm_ctrl
    import gcm_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  logic      i_blk_valid,
    input  gcm_blk_t  i_blk_data,
    input  logic      i_blk_is_aad,
    input  logic      i_finish,
    input  gcm_len_t  i_len_blk,
    output logic      o_busy,
    output logic      o_seq_error,
    gcm_stage_if.ctrl stage
);

    gcm_phase_e phase;

    logic       r_blk_valid;
    gcm_blk_t   r_blk_data;
    logic       r_blk_is_aad;
    logic [1:0] r_drain;

    logic       w_take_aad;
    logic       w_take_text;
    logic       w_order_err;

    // input capture, a block arriving with start is discarded
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            r_blk_valid <= 1'b0;
        end
        else
        begin
            r_blk_valid <= i_blk_valid && !i_start;
        end
    end

    always_ff @(posedge clk)
    begin
        r_blk_data   <= i_blk_data;
        r_blk_is_aad <= i_blk_is_aad;
    end

    always_comb
    begin
        w_take_aad  = r_blk_valid && r_blk_is_aad && (phase == PH_AAD);
        w_take_text = r_blk_valid && !r_blk_is_aad &&
                      ((phase == PH_AAD) || (phase == PH_TEXT));
        // aad after text breaks GCM ordering
        w_order_err = r_blk_valid && r_blk_is_aad && (phase == PH_TEXT);
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            phase           <= PH_IDLE;
            o_busy          <= 1'b0;
            o_seq_error     <= 1'b0;
            r_drain         <= 2'b00;
            stage.blk_valid <= 1'b0;
            stage.blk_phase <= PH_IDLE;
            stage.new_msg   <= 1'b0;
        end
        else
        begin
            stage.new_msg   <= i_start;
            stage.blk_valid <= 1'b0;
            r_drain         <= {r_drain[0], 1'b0};
            if (i_start)
            begin
                phase       <= PH_AAD;
                o_busy      <= 1'b1;
                o_seq_error <= 1'b0;
                r_drain     <= 2'b00;
            end
            else
            begin
                // tag leaves the pipeline two edges after PH_TAG ends
                if (r_drain[1])
                begin
                    o_busy <= 1'b0;
                end
                case (phase)
                    PH_AAD, PH_TEXT:
                    begin
                        stage.blk_valid <= w_take_aad || w_take_text;
                        stage.blk_phase <= w_take_aad ? PH_AAD : PH_TEXT;
                        if (w_order_err)
                        begin
                            o_seq_error <= 1'b1;
                        end
                        if (i_finish)
                        begin
                            phase <= PH_LEN;
                        end
                        else if (w_take_text)
                        begin
                            phase <= PH_TEXT;
                        end
                    end
                    PH_LEN:
                    begin
                        // length block goes down the same path as data
                        stage.blk_valid <= 1'b1;
                        stage.blk_phase <= PH_LEN;
                        phase           <= PH_TAG;
                    end
                    PH_TAG:
                    begin
                        phase   <= PH_IDLE;
                        r_drain <= 2'b01;
                    end
                    default:
                    begin
                        phase <= PH_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stage.blk_data <= (phase == PH_LEN) ? i_len_blk : r_blk_data;
    end

    // start and finish of a message are separate host actions
    a_start_finish_apart: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_start && i_finish));

    // host sends blocks only while aad or text is open
    a_no_late_block: assert property (@(posedge clk) disable iff (!i_rst_n)
        r_blk_valid |-> (phase inside {PH_AAD, PH_TEXT}));

endmodule

/* hw/gcm_len_counter.sv */
module gcm_len_counter
    import gcm_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    gcm_stage_if.dp  stage,
    output gcm_len_t o_len_blk
);

    gcm_cnt_t aad_cnt;
    gcm_cnt_t txt_cnt;
    gcm_cnt_t w_aad_nxt;
    gcm_cnt_t w_txt_nxt;

    // block count to a 64-bit bit length
    function automatic logic [LEN_FIELD_W-1:0] bit_len(input gcm_cnt_t cnt);
        return {{(LEN_FIELD_W-CNT_W-BLK_BITS_LOG2){1'b0}}, cnt, {BLK_BITS_LOG2{1'b0}}};
    endfunction

    // next counts include the block on the interface this cycle
    always_comb
    begin
        w_aad_nxt = aad_cnt;
        w_txt_nxt = txt_cnt;
        if (stage.blk_valid && (stage.blk_phase == PH_AAD) && (aad_cnt != MAX_BLKS))
        begin
            w_aad_nxt = aad_cnt + 1'b1;
        end
        if (stage.blk_valid && (stage.blk_phase == PH_TEXT) && (txt_cnt != MAX_BLKS))
        begin
            w_txt_nxt = txt_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n || stage.new_msg)
        begin
            aad_cnt <= '0;
            txt_cnt <= '0;
        end
        else
        begin
            aad_cnt <= w_aad_nxt;
            txt_cnt <= w_txt_nxt;
        end
    end

    // the last block may still be in flight when finish arrives
    assign o_len_blk = {bit_len(w_aad_nxt), bit_len(w_txt_nxt)};

    // a block past the limit would go missing from the length block
    a_cnt_limit: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(stage.blk_valid && (stage.blk_phase == PH_AAD) && (aad_cnt == MAX_BLKS)) &&
        !(stage.blk_valid && (stage.blk_phase == PH_TEXT) && (txt_cnt == MAX_BLKS)));

endmodule

/* hw/gcm_pkg.sv */
package gcm_pkg;

    // block and counter widths
    localparam int BLK_W = 128;
    localparam int CNT_W = 32;

    // each half of the length block is a 64-bit bit count
    localparam int LEN_FIELD_W = 64;

    // 128 bits per block, so a block count becomes bits by a shift of 7
    localparam int BLK_BITS_LOG2 = 7;

    // full 16-byte blocks, one message at a time
    typedef logic [BLK_W-1:0] gcm_blk_t;
    typedef logic [CNT_W-1:0] gcm_cnt_t;

    // upper half aad bits, lower half text bits
    typedef logic [BLK_W-1:0] gcm_len_t;

    // GCM allows at most 2^32 - 2 text blocks per message
    localparam gcm_cnt_t MAX_BLKS = 32'hffff_fffe;

    // message phase, shared by controller, interface and datapath
    typedef enum logic [2:0] {
        PH_IDLE = 3'd0,
        PH_AAD  = 3'd1,
        PH_TEXT = 3'd2,
        PH_LEN  = 3'd3,
        PH_TAG  = 3'd4
    } gcm_phase_e;

endpackage

/* hw/gcm_stage_if.sv */
interface gcm_stage_if
    import gcm_pkg::*;
();

    // one strobe per block, blocks may come on consecutive cycles
    logic       blk_valid;
    gcm_blk_t   blk_data;
    gcm_phase_e blk_phase;

    // single-cycle pulse at message start
    logic       new_msg;

    modport ctrl (
        output blk_valid,
        output blk_data,
        output blk_phase,
        output new_msg
    );

    // hash stage and length counter only listen
    modport dp (
        input blk_valid,
        input blk_data,
        input blk_phase,
        input new_msg
    );

endinterface

/* hw/gcm_tag_unit.sv */
module gcm_tag_unit
    import gcm_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_start,
    input  gcm_blk_t i_ekj0,
    input  gcm_blk_t i_s,
    input  logic     i_s_update,
    output gcm_blk_t o_tag,
    output logic     o_tag_valid
);

    gcm_blk_t r_ekj0;

    // E(K,J0) arrives together with start
    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            r_ekj0 <= i_ekj0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            o_tag_valid <= 1'b0;
        end
        else
        begin
            o_tag_valid <= i_s_update;
        end
    end

    // T = S ^ E(K,J0), held until the next message completes
    always_ff @(posedge clk)
    begin
        if (i_s_update)
        begin
            o_tag <= i_s ^ r_ekj0;
        end
    end

endmodule

/* hw/gf128_pkg.sv */
package gf128_pkg;

    localparam int GF128_W = 128;

    // bit 0 is the x^0 coefficient and sits at the msb, as in GCM
    typedef logic [0:GF128_W-1] gf128_t;

    // x^128 + x^7 + x^2 + x + 1 in reflected order
    localparam gf128_t GF128_R = {8'he1, 120'd0};

    // shift-and-add multiply in the GCM field
    // v walks through y times x^i while z collects the partial sums
    function automatic gf128_t gf128_mul(input gf128_t x, input gf128_t y);
        gf128_t z;
        gf128_t v;
        z = '0;
        v = y;
        for (int i = 0; i < GF128_W; i++)
        begin
            if (x[i])
            begin
                z = z ^ v;
            end
            // multiply v by x, reduce when x^127 falls off the end
            if (v[GF128_W-1])
            begin
                v = (v >> 1) ^ GF128_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

endpackage

/* hw/ghash_stage.sv */
module ghash_stage
    import gcm_pkg::*;
    import gf128_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  gcm_blk_t i_h,
    gcm_stage_if.dp  stage,
    output gcm_blk_t o_s,
    output logic     o_s_update
);

    gcm_blk_t r_h;
    gcm_blk_t r_blk;
    gcm_blk_t r_s;
    logic     r_blk_valid;
    logic     r_blk_is_len;

    gf128_t   w_x;
    gf128_t   w_prod;

    // S <- (S ^ X) * H
    always_comb
    begin
        w_x    = r_s ^ r_blk;
        w_prod = gf128_mul(w_x, r_h);
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n || stage.new_msg)
        begin
            r_blk_valid  <= 1'b0;
            r_blk_is_len <= 1'b0;
            o_s_update   <= 1'b0;
        end
        else
        begin
            r_blk_valid  <= stage.blk_valid;
            r_blk_is_len <= stage.blk_valid && (stage.blk_phase == PH_LEN);
            // S holds the final hash once the length block is in
            o_s_update   <= r_blk_valid && r_blk_is_len;
        end
    end

    // H is taken one cycle after i_start, with new_msg
    always_ff @(posedge clk)
    begin
        if (stage.new_msg)
        begin
            r_h <= i_h;
            r_s <= '0;
        end
        else if (r_blk_valid)
        begin
            r_s <= w_prod;
        end
        if (stage.blk_valid)
        begin
            r_blk <= stage.blk_data;
        end
    end

    assign o_s = r_s;

endmodule

/* testbench/tb_gcm_auth.sv */
module tb_gcm_auth
    import gcm_pkg::*;
();

    // finish edge to tag pulse
    localparam int TAG_LATENCY  = 4;
    localparam int TAG_WAIT_MAX = 12;
    // the whole run is roughly a hundred cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    // GCM test case 2, zero key and zero IV
    localparam gcm_blk_t TC2_H    = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam gcm_blk_t TC2_EKJ0 = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam gcm_blk_t TC2_C    = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam gcm_blk_t TC2_TAG  = 128'hab6e47d42cec13bdf53a67b21257bddf;

    logic     clk;
    logic     i_rst_n;
    logic     i_start;
    gcm_blk_t i_h;
    gcm_blk_t i_ekj0;
    logic     i_blk_valid;
    gcm_blk_t i_blk_data;
    logic     i_blk_is_aad;
    logic     i_finish;
    gcm_blk_t o_tag;
    logic     o_tag_valid;
    logic     o_busy;
    logic     o_seq_error;

    // reference state of the message in flight
    gcm_blk_t aad_q[$];
    gcm_blk_t txt_q[$];
    gcm_blk_t model_h;
    gcm_blk_t model_ekj0;
    logic     model_in_text;
    logic     model_seq_err;

    int error_cnt = 0;
    int cycle_cnt = 0;
    int seed_val;

    gcm_auth_top dut0 (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_h          (i_h),
        .i_ekj0       (i_ekj0),
        .i_blk_valid  (i_blk_valid),
        .i_blk_data   (i_blk_data),
        .i_blk_is_aad (i_blk_is_aad),
        .i_finish     (i_finish),
        .o_tag        (o_tag),
        .o_tag_valid  (o_tag_valid),
        .o_busy       (o_busy),
        .o_seq_error  (o_seq_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "stopped on timeout");
        end
    end

    // leftmost bit of a block is the x^0 coefficient
    function automatic logic [127:0] reverse_bits(input logic [127:0] v);
        logic [127:0] r;
        for (int i = 0; i < 128; i++)
        begin
            r[i] = v[127-i];
        end
        return r;
    endfunction

    // carry-less product, then reduction by x^128 + x^7 + x^2 + x + 1
    function automatic gcm_blk_t field_mul(input gcm_blk_t a_blk, input gcm_blk_t b_blk);
        logic [127:0] a;
        logic [127:0] b;
        logic [254:0] p;
        a = reverse_bits(a_blk);
        b = reverse_bits(b_blk);
        p = '0;
        for (int k = 0; k < 128; k++)
        begin
            if (a[k])
            begin
                p = p ^ ({127'd0, b} << k);
            end
        end
        for (int k = 254; k >= 128; k--)
        begin
            if (p[k])
            begin
                p[k]     = 1'b0;
                p[k-121] = ~p[k-121];
                p[k-126] = ~p[k-126];
                p[k-127] = ~p[k-127];
                p[k-128] = ~p[k-128];
            end
        end
        return reverse_bits(p[127:0]);
    endfunction

    // 128 bits per full block
    function automatic gcm_len_t len_block(input int n_aad, input int n_txt);
        logic [63:0] a_bits;
        logic [63:0] t_bits;
        a_bits = n_aad;
        t_bits = n_txt;
        return {a_bits * 64'd128, t_bits * 64'd128};
    endfunction

    function automatic gcm_blk_t model_tag();
        gcm_blk_t s;
        s = '0;
        foreach (aad_q[i])
        begin
            s = field_mul(s ^ aad_q[i], model_h);
        end
        foreach (txt_q[i])
        begin
            s = field_mul(s ^ txt_q[i], model_h);
        end
        s = field_mul(s ^ len_block(aad_q.size(), txt_q.size()), model_h);
        return s ^ model_ekj0;
    endfunction

    function automatic gcm_blk_t rand_blk();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_blk(input string name, input gcm_blk_t got, input gcm_blk_t exp);
        if (got !== exp)
        begin
            error_cnt++;
            abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            error_cnt++;
            abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cnt(input string name, input gcm_cnt_t got, input gcm_cnt_t exp);
        if (got !== exp)
        begin
            error_cnt++;
            abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_msg(input gcm_blk_t h, input gcm_blk_t ekj0);
        aad_q.delete();
        txt_q.delete();
        model_h       = h;
        model_ekj0    = ekj0;
        model_in_text = 1'b0;
        model_seq_err = 1'b0;
        // H and E(K,J0) stay on the pins for the whole message
        i_h     = h;
        i_ekj0  = ekj0;
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
        check_bit("o_busy", o_busy, 1'b1);
        check_bit("o_seq_error", o_seq_error, 1'b0);
    endtask

    task automatic send_blk(input gcm_blk_t data, input logic is_aad);
        if (is_aad && model_in_text)
        begin
            // aad after text is dropped and flagged
            model_seq_err = 1'b1;
        end
        else if (is_aad)
        begin
            aad_q.push_back(data);
        end
        else
        begin
            txt_q.push_back(data);
            model_in_text = 1'b1;
        end
        i_blk_valid  = 1'b1;
        i_blk_data   = data;
        i_blk_is_aad = is_aad;
        next_cycle();
        i_blk_valid  = 1'b0;
    endtask

    task automatic finish_and_check();
        gcm_blk_t exp_tag;
        int       edges;
        exp_tag  = model_tag();
        i_finish = 1'b1;
        next_cycle();
        i_finish = 1'b0;
        next_cycle();
        edges = 1;
        while (!o_tag_valid && (edges < TAG_WAIT_MAX))
        begin
            check_bit("o_busy", o_busy, 1'b1);
            next_cycle();
            edges++;
        end
        if (!o_tag_valid)
        begin
            error_cnt++;
            abort_run($sformatf("no tag valid pulse within %0d cycles of finish", TAG_WAIT_MAX));
        end
        check_cnt("o_tag_valid latency", edges, TAG_LATENCY);
        check_blk("o_tag", o_tag, exp_tag);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_seq_error", o_seq_error, model_seq_err);
        next_cycle();
        // single-cycle pulse, tag held afterwards
        check_bit("o_tag_valid", o_tag_valid, 1'b0);
        check_blk("o_tag", o_tag, exp_tag);
    endtask

    task automatic test_known_answer();
        start_msg(TC2_H, TC2_EKJ0);
        send_blk(TC2_C, 1'b0);
        check_blk("model tag", model_tag(), TC2_TAG);
        finish_and_check();
        check_blk("o_tag", o_tag, TC2_TAG);
    endtask

    task automatic test_back_to_back();
        check_blk("length model", len_block(3, 5), {64'd384, 64'd640});
        start_msg(rand_blk(), rand_blk());
        repeat (3) send_blk(rand_blk(), 1'b1);
        repeat (5) send_blk(rand_blk(), 1'b0);
        finish_and_check();
    endtask

    task automatic test_aad_only_and_empty();
        gcm_blk_t ekj0;
        start_msg(rand_blk(), rand_blk());
        repeat (2) send_blk(rand_blk(), 1'b1);
        finish_and_check();
        ekj0 = rand_blk();
        start_msg(rand_blk(), ekj0);
        finish_and_check();
        check_blk("o_tag", o_tag, ekj0);
    endtask

    task automatic test_order_error();
        start_msg(rand_blk(), rand_blk());
        send_blk(rand_blk(), 1'b1);
        send_blk(rand_blk(), 1'b0);
        send_blk(rand_blk(), 1'b1);
        send_blk(rand_blk(), 1'b0);
        finish_and_check();
        check_bit("o_seq_error", o_seq_error, 1'b1);
        // the next start must clear the flag
        start_msg(rand_blk(), rand_blk());
        send_blk(rand_blk(), 1'b0);
        finish_and_check();
    endtask

    task automatic test_busy_and_restart();
        check_bit("o_busy", o_busy, 1'b0);
        start_msg(rand_blk(), rand_blk());
        repeat (2) send_blk(rand_blk(), 1'b0);
        finish_and_check();
        // second message right away with fresh keys
        start_msg(rand_blk(), rand_blk());
        send_blk(rand_blk(), 1'b1);
        repeat (2) send_blk(rand_blk(), 1'b0);
        finish_and_check();
    endtask

    initial
    begin
        seed_val     = $urandom(32'h4e61);
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_h          = '0;
        i_ekj0       = '0;
        i_blk_valid  = 1'b0;
        i_blk_data   = '0;
        i_blk_is_aad = 1'b0;
        i_finish     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_tag_valid", o_tag_valid, 1'b0);
        check_bit("o_seq_error", o_seq_error, 1'b0);
        i_rst_n = 1'b1;
        next_cycle();

        test_known_answer();
        test_back_to_back();
        test_aad_only_and_empty();
        test_order_error();
        test_busy_and_restart();

        if (error_cnt == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Verification failed");
            $fatal(1, "checks failed");
        end
    end

endmodule
